//--- bpu_pkg.sv
package bpu_pkg;

	// ----------------------------------------------------------
	// Width constants
	// ----------------------------------------------------------

	// Word program counter, byte address bits [31:2]
	localparam int WPC_W = 30;
	// Local history length
	localparam int LPHR_W = 4;
	// Widest table index, smaller tables use the low bits
	localparam int IDX_W = 8;

	// ----------------------------------------------------------
	// Encodings
	// ----------------------------------------------------------

	// Branch class from decode
	typedef enum logic [1:0] {
		branch_invalid   = 2'd0,
		branch_immediate = 2'd1,
		branch_indirect  = 2'd2,
		branch_condition = 2'd3
	} branch_e;

	// Compare opcode for conditional branches
	typedef enum logic [2:0] {
		cmp_eql = 3'd0,
		cmp_neq = 3'd1,
		cmp_lss = 3'd2,
		cmp_ger = 3'd3,
		cmp_leq = 3'd4,
		cmp_geq = 3'd5,
		cmp_ltu = 3'd6,
		cmp_geu = 3'd7
	} cmp_e;

	// Predictor view of a branch
	typedef enum logic [1:0] {
		kind_pc_relative = 2'd0,
		kind_absolute    = 2'd1,
		kind_call        = 2'd2,
		kind_return      = 2'd3
	} br_kind_e;

	// ----------------------------------------------------------
	// Records
	// ----------------------------------------------------------

	typedef struct packed {
		logic        valid;
		branch_e     branch;
		cmp_e        cmp;
		logic        branch_link;
		logic [25:0] inst25_0;
	} decode_t;

	// Made at fetch, carried to execute by the core
	typedef struct packed {
		logic              taken;
		logic [WPC_W-1:0]  npc;
		logic [LPHR_W-1:0] lphr;
		logic [IDX_W-1:0]  lphr_index;
	} predict_t;

	typedef struct packed {
		logic              flush;
		logic              br_taken;
		logic [WPC_W-1:0]  pc;
		logic [WPC_W-1:0]  br_target;
		br_kind_e          br_kind;
		logic              btb_update;
		logic              bht_update;
		logic              lpht_update;
		logic [LPHR_W-1:0] lphr;
		logic [IDX_W-1:0]  lphr_index;
	} update_t;

endpackage

//--- bpu_btb.sv
`timescale 1ns/1ps

module bpu_btb #(
	parameter int BTB_DEPTH = 64
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [bpu_pkg::WPC_W-1:0] rd_pc_i,
	output logic                      hit_o,
	output logic [bpu_pkg::WPC_W-1:0] target_o,
	output bpu_pkg::br_kind_e         kind_o,
	input  bpu_pkg::update_t          update_i,
	input  logic                      stall_i
);

	localparam int IW = $clog2(BTB_DEPTH);
	localparam int TAG_W = bpu_pkg::WPC_W - IW;

	// Entry storage, only the valid bits are cleared
	logic                      valid_q [BTB_DEPTH];
	logic [TAG_W-1:0]          tag_q [BTB_DEPTH];
	logic [bpu_pkg::WPC_W-1:0] target_q [BTB_DEPTH];
	bpu_pkg::br_kind_e         kind_q [BTB_DEPTH];

	logic [IW-1:0]    rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IW-1:0]    wr_idx;
	logic [TAG_W-1:0] wr_tag;
	logic             wr_en;

	// ----------------------------------------------------------
	// Lookup
	// ----------------------------------------------------------
	assign rd_idx = rd_pc_i[IW-1:0];
	assign rd_tag = rd_pc_i[bpu_pkg::WPC_W-1:IW];

	assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
	assign target_o = target_q[rd_idx];
	assign kind_o   = kind_q[rd_idx];

	// ----------------------------------------------------------
	// Write from the resolve side
	// ----------------------------------------------------------
	assign wr_idx = update_i.pc[IW-1:0];
	assign wr_tag = update_i.pc[bpu_pkg::WPC_W-1:IW];
	assign wr_en  = update_i.btb_update && !stall_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < BTB_DEPTH; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// Tag, target and kind follow the valid bit
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_q[wr_idx]    <= wr_tag;
			target_q[wr_idx] <= update_i.br_target;
			kind_q[wr_idx]   <= update_i.br_kind;
		end
	end

endmodule

//--- bpu_lhp.sv
`timescale 1ns/1ps

module bpu_lhp #(
	parameter int LHT_DEPTH = 64,
	parameter int PHT_DEPTH = 256
) (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic [bpu_pkg::WPC_W-1:0]  rd_pc_i,
	output logic                       taken_o,
	output logic [bpu_pkg::LPHR_W-1:0] lphr_o,
	output logic [bpu_pkg::IDX_W-1:0]  lphr_index_o,
	input  bpu_pkg::update_t           update_i,
	input  logic                       stall_i
);

	localparam int LHT_IW = $clog2(LHT_DEPTH);
	localparam int PHT_IW = $clog2(PHT_DEPTH);

	logic [bpu_pkg::LPHR_W-1:0] lht_q [LHT_DEPTH];
	logic [1:0]                 pht_q [PHT_DEPTH];

	logic [LHT_IW-1:0]          rd_lht_idx;
	logic [bpu_pkg::IDX_W-1:0]  rd_hash;
	logic [LHT_IW-1:0]          wr_lht_idx;
	logic [bpu_pkg::IDX_W-1:0]  wr_hash;
	logic [1:0]                 ctr_old;
	logic [1:0]                 ctr_new;
	logic                       train;

	// Counter index, PC bits xor history
	function automatic logic [bpu_pkg::IDX_W-1:0] pht_hash(
		input logic [bpu_pkg::IDX_W-1:0]  pc_low,
		input logic [bpu_pkg::LPHR_W-1:0] hist
	);
		logic [bpu_pkg::IDX_W-1:0] hist_ext;
		hist_ext = '0;
		hist_ext[bpu_pkg::LPHR_W-1:0] = hist;
		return pc_low ^ hist_ext;
	endfunction

	// ----------------------------------------------------------
	// Fetch lookup
	// ----------------------------------------------------------
	assign rd_lht_idx = rd_pc_i[LHT_IW-1:0];
	assign lphr_o     = lht_q[rd_lht_idx];
	assign rd_hash    = pht_hash(rd_pc_i[bpu_pkg::IDX_W-1:0], lphr_o);
	assign taken_o    = pht_q[rd_hash[PHT_IW-1:0]][1];

	always_comb begin
		lphr_index_o = '0;
		lphr_index_o[LHT_IW-1:0] = rd_lht_idx;
	end

	// ----------------------------------------------------------
	// Training with the history carried by the prediction
	// ----------------------------------------------------------
	assign train      = update_i.lpht_update && !stall_i;
	assign wr_lht_idx = update_i.lphr_index[LHT_IW-1:0];
	assign wr_hash    = pht_hash(update_i.pc[bpu_pkg::IDX_W-1:0], update_i.lphr);
	assign ctr_old    = pht_q[wr_hash[PHT_IW-1:0]];

	// Saturating move toward the outcome
	always_comb begin
		ctr_new = ctr_old;
		if (update_i.br_taken && ctr_old != 2'b11) begin
			ctr_new = ctr_old + 2'd1;
		end else if (!update_i.br_taken && ctr_old != 2'b00) begin
			ctr_new = ctr_old - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < LHT_DEPTH; i++) begin
				lht_q[i] <= '0;
			end
			// Weakly not taken
			for (int j = 0; j < PHT_DEPTH; j++) begin
				pht_q[j] <= 2'b01;
			end
		end else if (train) begin
			lht_q[wr_lht_idx] <= {update_i.lphr[bpu_pkg::LPHR_W-2:0], update_i.br_taken};
			pht_q[wr_hash[PHT_IW-1:0]] <= ctr_new;
		end
	end

endmodule

//--- bpu_ras.sv
`timescale 1ns/1ps

module bpu_ras #(
	parameter int RAS_DEPTH = 8
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      push_i,
	input  logic                      pop_i,
	input  logic [bpu_pkg::WPC_W-1:0] push_addr_i,
	output logic [bpu_pkg::WPC_W-1:0] top_o
);

	localparam int PTR_W = $clog2(RAS_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(RAS_DEPTH);

	logic [bpu_pkg::WPC_W-1:0] stack_q [RAS_DEPTH];
	logic [PTR_W-1:0]          ptr_q;
	logic [PTR_W-1:0]          ptr_inc;
	logic [PTR_W:0]            count_q;
	logic                      empty;

	assign empty   = (count_q == '0);
	assign ptr_inc = ptr_q + PTR_W'(1);
	assign top_o   = empty ? '0 : stack_q[ptr_q];

	// Pointer and fill level
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ptr_q   <= '0;
			count_q <= '0;
		end else if (push_i && pop_i) begin
			if (empty) begin
				count_q <= (PTR_W + 1)'(1);
			end
		end else if (push_i) begin
			ptr_q <= ptr_inc;
			// Oldest entry is lost once full
			if (count_q != FULL_CNT) begin
				count_q <= count_q + (PTR_W + 1)'(1);
			end
		end else if (pop_i && !empty) begin
			ptr_q   <= ptr_q - PTR_W'(1);
			count_q <= count_q - (PTR_W + 1)'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push_i && pop_i) begin
			stack_q[ptr_q] <= push_addr_i;
		end else if (push_i) begin
			stack_q[ptr_inc] <= push_addr_i;
		end
	end

endmodule

//--- bpu_fetch.sv
`timescale 1ns/1ps

module bpu_fetch #(
	parameter int BTB_DEPTH = 64,
	parameter int LHT_DEPTH = 64,
	parameter int PHT_DEPTH = 256,
	parameter int RAS_DEPTH = 8
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic [31:0]       fetch_pc_i,
	output bpu_pkg::predict_t predict_o,
	input  bpu_pkg::update_t  update_i,
	input  logic              resolve_valid_i,
	input  logic              stall_i
);

	logic [bpu_pkg::WPC_W-1:0]  rd_pc;
	logic [bpu_pkg::WPC_W-1:0]  seq_pc;
	logic [bpu_pkg::WPC_W-1:0]  npc;
	logic                       btb_hit;
	logic [bpu_pkg::WPC_W-1:0]  btb_target;
	bpu_pkg::br_kind_e          btb_kind;
	logic                       dir_taken;
	logic [bpu_pkg::LPHR_W-1:0] lphr;
	logic [bpu_pkg::IDX_W-1:0]  lphr_index;
	logic                       resolve_ok;
	logic                       ras_push;
	logic                       ras_pop;
	logic [bpu_pkg::WPC_W-1:0]  ras_top;

	assign rd_pc  = fetch_pc_i[31:2];
	assign seq_pc = rd_pc + 30'd1;

	bpu_btb #(.BTB_DEPTH(BTB_DEPTH)) u_btb (
		.clk(clk), .rst_n_i(rst_n_i), .rd_pc_i(rd_pc), .hit_o(btb_hit),
		.target_o(btb_target), .kind_o(btb_kind), .update_i(update_i), .stall_i(stall_i)
	);

	bpu_lhp #(.LHT_DEPTH(LHT_DEPTH), .PHT_DEPTH(PHT_DEPTH)) u_lhp (
		.clk(clk), .rst_n_i(rst_n_i), .rd_pc_i(rd_pc), .taken_o(dir_taken),
		.lphr_o(lphr), .lphr_index_o(lphr_index), .update_i(update_i), .stall_i(stall_i)
	);

	// Calls and returns tracked at resolve, no speculative repair
	assign resolve_ok = resolve_valid_i && !stall_i;
	assign ras_push   = resolve_ok && (update_i.br_kind == bpu_pkg::kind_call);
	assign ras_pop    = resolve_ok && (update_i.br_kind == bpu_pkg::kind_return);

	bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
		.clk(clk), .rst_n_i(rst_n_i), .push_i(ras_push), .pop_i(ras_pop),
		.push_addr_i(update_i.pc + 30'd1), .top_o(ras_top)
	);

	// Next PC select
	always_comb begin
		npc = seq_pc;
		if (btb_hit) begin
			case (btb_kind)
				bpu_pkg::kind_return:   npc = ras_top;
				bpu_pkg::kind_call,
				bpu_pkg::kind_absolute: npc = btb_target;
				default:                npc = dir_taken ? btb_target : seq_pc;
			endcase
		end
	end

	assign predict_o.taken      = (npc != seq_pc);
	assign predict_o.npc        = npc;
	assign predict_o.lphr       = lphr;
	assign predict_o.lphr_index = lphr_index;

endmodule

//--- bpf.sv
`timescale 1ns/1ps

module bpf (
	input  logic              csr_flush_i,
	input  logic              stall_i,
	input  logic [31:0]       pc_i,
	input  logic [31:0]       rj_i,
	input  logic [31:0]       rd_i,
	input  logic [31:0]       csr_target_i,
	input  bpu_pkg::decode_t  decode_i,
	input  bpu_pkg::predict_t predict_i,
	output bpu_pkg::update_t  update_o,
	output logic [31:0]       pc_link_o
);

	logic [25:0]       offs;
	logic [4:0]        rj_index;
	logic [4:0]        rd_index;
	logic [31:0]       offs_26;
	logic [31:0]       offs_16;
	logic [31:0]       seq_pc;
	logic [31:0]       target;
	logic [31:0]       predict_npc;
	logic              taken;
	logic              is_cond;
	logic              is_branch;
	logic              mispredict;
	bpu_pkg::br_kind_e kind;

	// ----------------------------------------------------------
	// Instruction fields
	// ----------------------------------------------------------
	assign offs     = decode_i.inst25_0;
	assign rj_index = offs[9:5];
	assign rd_index = offs[4:0];

	// Long offset has its high part in the low field
	assign offs_26 = {{4{offs[9]}}, offs[9:0], offs[25:10], 2'b00};
	assign offs_16 = {{14{offs[25]}}, offs[25:10], 2'b00};

	assign is_cond   = (decode_i.branch == bpu_pkg::branch_condition);
	assign is_branch = (decode_i.branch != bpu_pkg::branch_invalid);
	assign seq_pc    = pc_i + 32'd4;

	// ----------------------------------------------------------
	// Condition
	// ----------------------------------------------------------
	always_comb begin
		taken = 1'b0;
		if (is_cond) begin
			case (decode_i.cmp)
				bpu_pkg::cmp_eql: taken = (rj_i == rd_i);
				bpu_pkg::cmp_neq: taken = (rj_i != rd_i);
				bpu_pkg::cmp_lss: taken = ($signed(rj_i) < $signed(rd_i));
				bpu_pkg::cmp_ger: taken = ($signed(rj_i) > $signed(rd_i));
				bpu_pkg::cmp_leq: taken = ($signed(rj_i) <= $signed(rd_i));
				bpu_pkg::cmp_geq: taken = ($signed(rj_i) >= $signed(rd_i));
				bpu_pkg::cmp_ltu: taken = (rj_i < rd_i);
				default:          taken = (rj_i >= rd_i);
			endcase
		end else if (is_branch) begin
			taken = 1'b1;
		end
	end

	// True next PC
	always_comb begin
		case (decode_i.branch)
			bpu_pkg::branch_immediate: target = pc_i + offs_26;
			bpu_pkg::branch_indirect:  target = rj_i + offs_16;
			bpu_pkg::branch_condition: target = taken ? pc_i + offs_16 : seq_pc;
			default:                   target = seq_pc;
		endcase
	end

	// ----------------------------------------------------------
	// Kind seen by the predictor
	// ----------------------------------------------------------
	always_comb begin
		if ((decode_i.branch == bpu_pkg::branch_indirect && rd_index == 5'd1) ||
				decode_i.branch_link) begin
			kind = bpu_pkg::kind_call;
		end else if (decode_i.branch == bpu_pkg::branch_indirect && rj_index == 5'd1 &&
				offs_16 == 32'd0) begin
			kind = bpu_pkg::kind_return;
		end else if (decode_i.branch == bpu_pkg::branch_immediate ||
				decode_i.branch == bpu_pkg::branch_indirect) begin
			kind = bpu_pkg::kind_absolute;
		end else begin
			kind = bpu_pkg::kind_pc_relative;
		end
	end

	assign predict_npc = {predict_i.npc, 2'b00};
	assign mispredict  = decode_i.valid && !stall_i && (predict_npc != target);
	assign pc_link_o   = seq_pc;

	// Update record
	always_comb begin
		update_o.flush       = mispredict || csr_flush_i;
		update_o.br_taken    = taken;
		update_o.pc          = pc_i[31:2];
		update_o.br_target   = csr_flush_i ? csr_target_i[31:2] : target[31:2];
		update_o.br_kind     = kind;
		update_o.btb_update  = mispredict || csr_flush_i;
		update_o.bht_update  = is_branch;
		update_o.lpht_update = is_branch;
		update_o.lphr        = predict_i.lphr;
		update_o.lphr_index  = predict_i.lphr_index;
	end

endmodule

//--- bpu_top.sv
`timescale 1ns/1ps

module bpu_top #(
	parameter int BTB_DEPTH = 64,
	parameter int LHT_DEPTH = 64,
	parameter int PHT_DEPTH = 256,
	parameter int RAS_DEPTH = 8
) (
	input  logic              clk,
	input  logic              rst_n_i,
	// Fetch side
	input  logic [31:0]       fetch_pc_i,
	output bpu_pkg::predict_t predict_o,
	// Resolve side
	input  logic              csr_flush_i,
	input  logic              stall_i,
	input  logic [31:0]       pc_i,
	input  logic [31:0]       rj_i,
	input  logic [31:0]       rd_i,
	input  logic [31:0]       csr_target_i,
	input  bpu_pkg::decode_t  decode_i,
	input  bpu_pkg::predict_t predict_i,
	output bpu_pkg::update_t  update_o,
	output logic [31:0]       pc_link_o
);

	logic resolve_valid;

	// RAS only follows resolves not overridden by a CSR redirect
	assign resolve_valid = decode_i.valid && !csr_flush_i;

	bpu_fetch #(
		.BTB_DEPTH(BTB_DEPTH), .LHT_DEPTH(LHT_DEPTH),
		.PHT_DEPTH(PHT_DEPTH), .RAS_DEPTH(RAS_DEPTH)
	) u_fetch (
		.clk(clk), .rst_n_i(rst_n_i), .fetch_pc_i(fetch_pc_i), .predict_o(predict_o),
		.update_i(update_o), .resolve_valid_i(resolve_valid), .stall_i(stall_i)
	);

	bpf u_bpf (
		.csr_flush_i(csr_flush_i), .stall_i(stall_i), .pc_i(pc_i), .rj_i(rj_i),
		.rd_i(rd_i), .csr_target_i(csr_target_i), .decode_i(decode_i),
		.predict_i(predict_i), .update_o(update_o), .pc_link_o(pc_link_o)
	);

endmodule

//--- tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu;

	localparam int  RESET_CYCLES = 10;
	localparam time RESET_LIMIT  = 200;
	localparam time RUN_LIMIT    = 20000;
	localparam int  LHT_DEPTH    = 64;

	logic              clk;
	logic              rst_n;
	logic [31:0]       fetch_pc;
	bpu_pkg::predict_t predict_o;
	logic              csr_flush;
	logic              stall;
	logic [31:0]       pc;
	logic [31:0]       rj;
	logic [31:0]       rd;
	logic [31:0]       csr_target;
	bpu_pkg::decode_t  decode;
	bpu_pkg::predict_t predict_i;
	bpu_pkg::update_t  update_o;
	logic [31:0]       pc_link;

	// Fields of one test line
	logic [31:0] f_fetch, f_exp_npc, f_pc, f_rj, f_rd, f_csr_target, f_pred_npc;
	logic [31:0] f_exp_target, f_exp_link;
	logic        f_valid, f_link, f_stall, f_csr, f_exp_flush, f_exp_taken;
	logic [1:0]  f_branch;
	logic [2:0]  f_cmp;
	logic [25:0] f_inst;
	logic        exp_pred_taken;

	// Local history as the predictor should hold it
	logic [bpu_pkg::LPHR_W-1:0] hist_model [256];
	logic [bpu_pkg::LPHR_W-1:0] carried_lphr;
	logic [bpu_pkg::IDX_W-1:0]  carried_index;
	logic [bpu_pkg::IDX_W-1:0]  exp_fetch_index;
	bpu_pkg::br_kind_e          exp_kind;

	int    fd;
	int    n_fields;
	int    tests;
	int    failed_tests;
	int    mismatches;
	int    line_fails;
	int    cycles;
	bit    aborted;
	string line;

	bpu_top #(.LHT_DEPTH(LHT_DEPTH)) u_dut (
		.clk(clk), .rst_n_i(rst_n), .fetch_pc_i(fetch_pc), .predict_o(predict_o),
		.csr_flush_i(csr_flush), .stall_i(stall), .pc_i(pc), .rj_i(rj), .rd_i(rd),
		.csr_target_i(csr_target), .decode_i(decode), .predict_i(predict_i),
		.update_o(update_o), .pc_link_o(pc_link)
	);

	// History table entry selected by a byte address
	function automatic logic [7:0] hist_index(input logic [31:0] addr);
		return addr[9:2] & 8'(LHT_DEPTH - 1);
	endfunction

	// Call, return, absolute or PC-relative from the decode fields
	function automatic bpu_pkg::br_kind_e expected_kind(
		input logic [1:0]  branch,
		input logic        link,
		input logic [25:0] inst
	);
		logic indirect;
		indirect = (branch == bpu_pkg::branch_indirect);
		if ((indirect && inst[4:0] == 5'd1) || link) begin
			return bpu_pkg::kind_call;
		end
		if (indirect && inst[9:5] == 5'd1 && inst[25:10] == 16'd0) begin
			return bpu_pkg::kind_return;
		end
		if (branch == bpu_pkg::branch_immediate || indirect) begin
			return bpu_pkg::kind_absolute;
		end
		return bpu_pkg::kind_pc_relative;
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog for the whole run
	initial begin
		#(RUN_LIMIT);
		$display("timeout: simulation still running after %0t", RUN_LIMIT);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		fetch_pc = '0;
		csr_flush = 1'b0;
		stall = 1'b0;
		pc = '0;
		rj = '0;
		rd = '0;
		csr_target = '0;
		decode = '0;
		predict_i = '0;
		hist_model = '{default: '0};
		tests = 0;
		failed_tests = 0;
		mismatches = 0;
		aborted = 1'b0;

		// ----------------------------------------------------------
		// Reset
		// ----------------------------------------------------------
		cycles = 0;
		while (cycles < RESET_CYCLES && !aborted) begin
			@(posedge clk);
			cycles++;
			if ($time > RESET_LIMIT) begin
				$display("reset did not finish within %0t", RESET_LIMIT);
				aborted = 1'b1;
			end
		end
		#1;
		rst_n = 1'b1;

		fd = $fopen("bpu_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open bpu_tests.txt");
			aborted = 1'b1;
		end

		// ----------------------------------------------------------
		// One line per cycle, table writes seen by the next line
		// ----------------------------------------------------------
		while (!aborted && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f_fetch, f_exp_npc, f_valid, f_branch, f_cmp, f_link, f_inst, f_pc, f_rj,
				f_rd, f_stall, f_csr, f_csr_target, f_pred_npc, f_exp_flush, f_exp_taken,
				f_exp_target, f_exp_link);
			tests++;
			if (n_fields != 18) begin
				$display("test %0d: line has %0d fields instead of 18", tests, n_fields);
				failed_tests++;
				continue;
			end
			@(posedge clk);
			#1;
			fetch_pc = f_fetch;
			pc = f_pc;
			rj = f_rj;
			rd = f_rd;
			stall = f_stall;
			csr_flush = f_csr;
			csr_target = f_csr_target;
			decode.valid = f_valid;
			decode.branch = bpu_pkg::branch_e'(f_branch);
			decode.cmp = bpu_pkg::cmp_e'(f_cmp);
			decode.branch_link = f_link;
			decode.inst25_0 = f_inst;
			// Prediction as the core carried it, with the history held for pc
			carried_index = hist_index(f_pc);
			carried_lphr = hist_model[carried_index];
			predict_i = '0;
			predict_i.npc = f_pred_npc[31:2];
			predict_i.taken = (f_pred_npc != f_pc + 32'd4);
			predict_i.lphr = carried_lphr;
			predict_i.lphr_index = carried_index;
			exp_pred_taken = (f_exp_npc != f_fetch + 32'd4);
			exp_fetch_index = hist_index(f_fetch);
			exp_kind = expected_kind(f_branch, f_link, f_inst);
			#5;
			line_fails = 0;
			if ({predict_o.npc, 2'b00} !== f_exp_npc) begin
				$display("** Error: test %0d predict_o.npc got %h expected %h",
					tests, {predict_o.npc, 2'b00}, f_exp_npc);
				line_fails++;
			end
			if (predict_o.taken !== exp_pred_taken) begin
				$display("** Error: test %0d predict_o.taken got %h expected %h",
					tests, predict_o.taken, exp_pred_taken);
				line_fails++;
			end
			if (predict_o.lphr !== hist_model[exp_fetch_index]) begin
				$display("** Error: test %0d predict_o.lphr got %h expected %h",
					tests, predict_o.lphr, hist_model[exp_fetch_index]);
				line_fails++;
			end
			if (predict_o.lphr_index !== exp_fetch_index) begin
				$display("** Error: test %0d predict_o.lphr_index got %h expected %h",
					tests, predict_o.lphr_index, exp_fetch_index);
				line_fails++;
			end
			if (update_o.flush !== f_exp_flush) begin
				$display("** Error: test %0d update_o.flush got %h expected %h",
					tests, update_o.flush, f_exp_flush);
				line_fails++;
			end
			if (update_o.btb_update !== f_exp_flush) begin
				$display("** Error: test %0d update_o.btb_update got %h expected %h",
					tests, update_o.btb_update, f_exp_flush);
				line_fails++;
			end
			if (update_o.br_taken !== f_exp_taken) begin
				$display("** Error: test %0d update_o.br_taken got %h expected %h",
					tests, update_o.br_taken, f_exp_taken);
				line_fails++;
			end
			if ({update_o.br_target, 2'b00} !== f_exp_target) begin
				$display("** Error: test %0d update_o.br_target got %h expected %h",
					tests, {update_o.br_target, 2'b00}, f_exp_target);
				line_fails++;
			end
			if ({update_o.pc, 2'b00} !== {f_pc[31:2], 2'b00}) begin
				$display("** Error: test %0d update_o.pc got %h expected %h",
					tests, {update_o.pc, 2'b00}, {f_pc[31:2], 2'b00});
				line_fails++;
			end
			if (update_o.br_kind !== exp_kind) begin
				$display("** Error: test %0d update_o.br_kind got %h expected %h",
					tests, update_o.br_kind, exp_kind);
				line_fails++;
			end
			if (update_o.lpht_update !== (f_branch != 2'd0)) begin
				$display("** Error: test %0d update_o.lpht_update got %h expected %h",
					tests, update_o.lpht_update, (f_branch != 2'd0));
				line_fails++;
			end
			if (update_o.lphr !== carried_lphr) begin
				$display("** Error: test %0d update_o.lphr got %h expected %h",
					tests, update_o.lphr, carried_lphr);
				line_fails++;
			end
			if (update_o.lphr_index !== carried_index) begin
				$display("** Error: test %0d update_o.lphr_index got %h expected %h",
					tests, update_o.lphr_index, carried_index);
				line_fails++;
			end
			if (pc_link !== f_exp_link) begin
				$display("** Error: test %0d pc_link_o got %h expected %h",
					tests, pc_link, f_exp_link);
				line_fails++;
			end
			// Outcome shifts into the history of a trained branch
			if (f_branch != 2'd0 && !f_stall) begin
				hist_model[carried_index] = {carried_lphr[bpu_pkg::LPHR_W-2:0], f_exp_taken};
			end
			mismatches += line_fails;
			if (line_fails == 0) begin
				$display("test %0d: ok", tests);
			end else begin
				$display("test %0d: %0d mismatches", tests, line_fails);
				failed_tests++;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (!aborted && tests == 0) begin
			$display("no tests found in bpu_tests.txt");
			aborted = 1'b1;
		end

		$display("%0d tests, %0d failed, %0d mismatches", tests, failed_tests, mismatches);
		if (!aborted && failed_tests == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- bpu_tests.txt
# fetch_pc exp_npc valid branch cmp link inst25_0 pc rj rd stall csr_flush csr_target pred_npc
# exp_flush exp_br_taken exp_br_target exp_link (all hex, byte addresses)
1000 1004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 4
fffffffc 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 4
400 404 1 3 0 0 1000 400 ffffffff 1 0 0 0 404 0 0 404 404
400 404 1 3 1 0 1000 400 ffffffff 1 0 0 0 410 0 1 410 404
400 404 1 3 2 0 1000 400 ffffffff 1 0 0 0 410 0 1 410 404
400 404 1 3 3 0 1000 400 ffffffff 1 0 0 0 404 0 0 404 404
400 404 1 3 4 0 1000 400 ffffffff 1 0 0 0 410 0 1 410 404
400 404 1 3 5 0 1000 400 ffffffff 1 0 0 0 404 0 0 404 404
400 404 1 3 6 0 1000 400 ffffffff 1 0 0 0 404 0 0 404 404
400 404 1 3 7 0 1000 400 ffffffff 1 0 0 0 410 0 1 410 404
400 404 1 3 0 0 1000 400 5 5 0 0 0 410 0 1 410 404
800 804 1 1 0 0 10000 800 0 0 0 0 0 804 1 1 900 804
800 900 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 4
1800 1804 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 4
2080 2084 1 2 0 0 20 2080 3000 0 0 0 0 2084 1 1 3000 2084
2080 0 1 1 0 1 100000 1040 0 0 0 0 0 1044 1 1 2040 1044
2080 1044 1 2 0 0 20 2080 1044 0 0 0 0 1044 0 1 1044 2084
2080 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 4
5000 5004 1 3 0 0 1000 400 5 5 0 1 8000 410 1 1 8000 404
10 14 0 0 0 0 0 0 0 0 0 1 c000 0 1 0 c000 4
3000 3004 1 1 0 0 10000 3000 0 0 1 0 0 3004 0 1 3100 3004
3000 3004 1 1 0 0 10000 3000 0 0 0 0 0 3004 1 1 3100 3004
3000 3100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 4

//--- files.f
bpu_pkg.sv
bpu_btb.sv
bpu_lhp.sv
bpu_ras.sv
bpu_fetch.sv
bpf.sv
bpu_top.sv
tb_bpu.sv

//--- Makefile
TOP = tb_bpu

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

obj_dir/V$(TOP): files.f $(wildcard *.sv)
	verilator --binary --timing --top-module $(TOP) -f files.f

lint:
	verilator --lint-only -Wall --timing --top-module bpu_top -f files.f

clean:
	rm -rf obj_dir
